// ==== rtl/channel_acq_controller.sv ====
// Channel acquisition controller
`timescale 1ns/1ps
`default_nettype none

module channel_acq_controller (
    input  wire                               ttc_clk,
    input  wire                               rst,
    input  wire trigger_pkg::chan_mask_t      chan_en,    // enabled channels
    input  wire [trigger_pkg::DELAY_W-1:0]    trig_delay, // cycles before channel trigger
    input  wire                               acq_trigger,
    input  wire trigger_pkg::acq_event_t      acq_event,
    input  wire trigger_pkg::chan_mask_t      chan_dones,
    input  wire                               fifo_full,  // acquisition FIFO
    output logic                              acq_ready,
    output trigger_pkg::chan_mask_t           chan_enable,
    output trigger_pkg::chan_mask_t           chan_trig,
    output logic                              fifo_push,
    output trigger_pkg::acq_event_t           fifo_data
);

    typedef enum logic [1:0] {
        IDLE,
        DELAY,
        WAIT_DONE,
        LOG
    } state_t;

    state_t                          state;
    logic [trigger_pkg::DELAY_W-1:0] delay_cnt;
    trigger_pkg::chan_mask_t         mask;      // chan_en at trigger time
    trigger_pkg::chan_mask_t         done_seen; // dones collected so far
    trigger_pkg::chan_mask_t         done_all;
    trigger_pkg::acq_event_t         event_q;
    logic                            fire;

    assign fire     = (state == DELAY) && (delay_cnt == '0); // trig_delay + 1 after acq_trigger
    assign done_all = done_seen | chan_dones;

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (acq_trigger) state <= DELAY;
                DELAY:     if (delay_cnt == '0) state <= WAIT_DONE;
                WAIT_DONE: if ((done_all & mask) == mask) state <= LOG;
                LOG:       if (!fifo_full) state <= IDLE; // hold until room
                default:   state <= IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (state == IDLE && acq_trigger) begin
            mask      <= chan_en;
            event_q   <= acq_event;
            delay_cnt <= trig_delay;
        end else if (state == DELAY && delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
    end

    // dones accumulate only while waiting, start clean each event
    always_ff @(posedge ttc_clk) begin
        if (state == WAIT_DONE) begin
            done_seen <= done_all;
        end else begin
            done_seen <= '0;
        end
    end

    // ----------------------------------------------------------------------
    // outputs
    // ----------------------------------------------------------------------
    assign fifo_push = (state == LOG) && !fifo_full;
    assign fifo_data = event_q;
    assign acq_ready = (state == IDLE) || fifo_push; // rises with the push
    assign chan_trig = fire ? mask : '0;

    // held from the trigger pulse until the event is logged
    assign chan_enable = (fire || state == WAIT_DONE || (state == LOG && fifo_full)) ?
                         mask : '0;

endmodule

`default_nettype wire

// ==== rtl/event_fifo.sv ====
// Show-ahead event FIFO
`timescale 1ns/1ps
`default_nettype none

module event_fifo #(
    parameter int WIDTH = 32
) (
    input  wire               ttc_clk,
    input  wire               rst,
    input  wire               push,
    input  wire [WIDTH-1:0]   push_data,
    input  wire               pop,
    output logic              full,
    output logic [WIDTH-1:0]  pop_data, // oldest entry while not empty
    output logic              empty
);

    logic [WIDTH-1:0]                   mem [trigger_pkg::FIFO_DEPTH];
    logic [trigger_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [trigger_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [trigger_pkg::FIFO_PTR_W:0]   count; // occupancy, one extra bit
    logic                               do_push;
    logic                               do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge ttc_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2^n
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full     = count[trigger_pkg::FIFO_PTR_W]; // count == FIFO_DEPTH
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== rtl/trigger_pkg.sv ====
// Trigger system shared definitions
`default_nettype none

package trigger_pkg;

    // ----------------------------------------------------------------------
    // sizes
    // ----------------------------------------------------------------------
    localparam int NUM_CHAN    = 5;  // channel FPGAs in the crate
    localparam int TRIG_NUM_W  = 24; // trigger / event number
    localparam int TRIG_TYPE_W = 5;  // muon fill, laser, pedestal ...
    localparam int TIMESTAMP_W = 44; // ttc_clk cycles
    localparam int DELAY_W     = 8;  // trigger delay setting
    localparam int FIFO_DEPTH  = 16; // power of two, entries per event FIFO
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);

    // numbering starts at 1, also after a channel B number reset
    localparam logic [TRIG_NUM_W-1:0] FIRST_TRIG_NUM = 1;

    // ----------------------------------------------------------------------
    // records
    // ----------------------------------------------------------------------
    typedef logic [NUM_CHAN-1:0] chan_mask_t; // one bit per channel

    // trigger FIFO entry, 73 bits
    typedef struct packed {
        logic [TIMESTAMP_W-1:0] timestamp;
        logic [TRIG_NUM_W-1:0]  trig_num;
        logic [TRIG_TYPE_W-1:0] trig_type;
    } trig_info_t;

    // acquisition FIFO entry, 29 bits
    typedef struct packed {
        logic [TRIG_NUM_W-1:0]  trig_num;
        logic [TRIG_TYPE_W-1:0] trig_type;
    } acq_event_t;

    // handed to the command manager, 97 bits
    typedef struct packed {
        logic [TRIG_NUM_W-1:0]  event_num;
        logic [TRIG_NUM_W-1:0]  trig_num;
        logic [TRIG_TYPE_W-1:0] trig_type;
        logic [TIMESTAMP_W-1:0] timestamp;
    } readout_info_t;

endpackage

`default_nettype wire

// ==== rtl/trigger_processor.sv ====
// Trigger processor
`timescale 1ns/1ps
`default_nettype none

module trigger_processor (
    input  wire                               ttc_clk,
    input  wire                               rst,
    input  wire                               trig_empty,
    input  wire trigger_pkg::trig_info_t      trig_data,
    input  wire                               acq_empty,
    input  wire trigger_pkg::acq_event_t      acq_data,
    input  wire                               readout_done, // ack from command manager
    output logic                              trig_pop,
    output logic                              acq_pop,
    output logic                              initiate_readout, // req
    output trigger_pkg::readout_info_t        readout,
    output logic                              error_trig_num,  // sticky
    output logic                              error_trig_type  // sticky
);

    typedef enum logic [1:0] {
        IDLE,    // wait for an entry in both FIFOs
        REQ,     // req high, wait for ack
        RELEASE  // req low, wait for ack low
    } state_t;

    state_t                             state;
    logic [trigger_pkg::TRIG_NUM_W-1:0] event_cnt;
    logic                               pop;

    assign pop = (state == IDLE) && !trig_empty && !acq_empty;

    // ----------------------------------------------------------------------
    // four-phase sequencing
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (pop) state <= REQ;
                REQ:     if (readout_done) state <= RELEASE;
                RELEASE: if (!readout_done) state <= IDLE; // readout finished
                default: state <= IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // pairing and checks
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            event_cnt       <= trigger_pkg::FIRST_TRIG_NUM;
            error_trig_num  <= 1'b0;
            error_trig_type <= 1'b0;
        end else if (pop) begin
            event_cnt <= event_cnt + 1'b1;
            if (trig_data.trig_num != acq_data.trig_num) begin
                error_trig_num <= 1'b1;
            end
            if (trig_data.trig_type != acq_data.trig_type) begin
                error_trig_type <= 1'b1;
            end
        end
    end

    // stays stable through REQ and RELEASE
    always_ff @(posedge ttc_clk) begin
        if (pop) begin
            readout.event_num <= event_cnt;
            readout.trig_num  <= trig_data.trig_num;
            readout.trig_type <= trig_data.trig_type;
            readout.timestamp <= trig_data.timestamp;
        end
    end

    assign trig_pop         = pop; // both FIFOs pop together
    assign acq_pop          = pop;
    assign initiate_readout = (state == REQ);

endmodule

`default_nettype wire

// ==== rtl/trigger_top.sv ====
// Trigger manager top level
`timescale 1ns/1ps
`default_nettype none

module trigger_top (
    input  wire                                 ttc_clk, // 40 MHz
    input  wire                                 rst,
    input  wire                                 rst_trigger_num,       // TTC channel B
    input  wire                                 rst_trigger_timestamp, // TTC channel B
    // trigger interface
    input  wire                                 ttc_trigger,
    input  wire [trigger_pkg::TRIG_TYPE_W-1:0]  trig_type,
    input  wire trigger_pkg::chan_mask_t        chan_en,
    input  wire [trigger_pkg::DELAY_W-1:0]      trig_delay,
    // channel interface
    input  wire trigger_pkg::chan_mask_t        chan_dones,
    output wire trigger_pkg::chan_mask_t        chan_enable,
    output wire trigger_pkg::chan_mask_t        chan_trig,
    // command manager interface
    input  wire                                 readout_done,
    output wire                                 initiate_readout,
    output wire trigger_pkg::readout_info_t     readout,
    // status
    output wire                                 trig_fifo_full,
    output wire                                 acq_fifo_full,
    output wire                                 error_trig_rate,
    output wire                                 error_trig_num,
    output wire                                 error_trig_type
);

    // ----------------------------------------------------------------------
    // internal connections
    // ----------------------------------------------------------------------
    logic                    acq_ready;
    logic                    acq_trigger;
    trigger_pkg::acq_event_t acq_event;

    logic                    trig_push;       // receiver -> trigger FIFO
    trigger_pkg::trig_info_t trig_push_data;
    logic                    trig_pop;        // trigger FIFO -> processor
    trigger_pkg::trig_info_t trig_pop_data;
    logic                    trig_empty;

    logic                    acq_push;        // controller -> acq FIFO
    trigger_pkg::acq_event_t acq_push_data;
    logic                    acq_pop;         // acq FIFO -> processor
    trigger_pkg::acq_event_t acq_pop_data;
    logic                    acq_empty;

    // ----------------------------------------------------------------------
    // instances
    // ----------------------------------------------------------------------
    ttc_trigger_receiver ttc_trigger_receiver (
        .ttc_clk               (ttc_clk),
        .rst                   (rst),
        .rst_trigger_num       (rst_trigger_num),
        .rst_trigger_timestamp (rst_trigger_timestamp),
        .ttc_trigger           (ttc_trigger),
        .trig_type             (trig_type),
        .acq_ready             (acq_ready),
        .fifo_full             (trig_fifo_full),
        .acq_trigger           (acq_trigger),
        .acq_event             (acq_event),
        .fifo_push             (trig_push),
        .fifo_data             (trig_push_data),
        .error_trig_rate       (error_trig_rate)
    );

    channel_acq_controller channel_acq_controller (
        .ttc_clk     (ttc_clk),
        .rst         (rst),
        .chan_en     (chan_en),
        .trig_delay  (trig_delay),
        .acq_trigger (acq_trigger),
        .acq_event   (acq_event),
        .chan_dones  (chan_dones),
        .fifo_full   (acq_fifo_full),
        .acq_ready   (acq_ready),
        .chan_enable (chan_enable),
        .chan_trig   (chan_trig),
        .fifo_push   (acq_push),
        .fifo_data   (acq_push_data)
    );

    // timestamp, trigger number and type of every accepted trigger
    event_fifo #(
        .WIDTH ($bits(trigger_pkg::trig_info_t))
    ) ttc_trigger_fifo (
        .ttc_clk   (ttc_clk),
        .rst       (rst),
        .push      (trig_push),
        .push_data (trig_push_data),
        .pop       (trig_pop),
        .full      (trig_fifo_full),
        .pop_data  (trig_pop_data),
        .empty     (trig_empty)
    );

    // trigger number and type of every acquired event
    event_fifo #(
        .WIDTH ($bits(trigger_pkg::acq_event_t))
    ) acq_event_fifo (
        .ttc_clk   (ttc_clk),
        .rst       (rst),
        .push      (acq_push),
        .push_data (acq_push_data),
        .pop       (acq_pop),
        .full      (acq_fifo_full),
        .pop_data  (acq_pop_data),
        .empty     (acq_empty)
    );

    trigger_processor trigger_processor (
        .ttc_clk          (ttc_clk),
        .rst              (rst),
        .trig_empty       (trig_empty),
        .trig_data        (trig_pop_data),
        .acq_empty        (acq_empty),
        .acq_data         (acq_pop_data),
        .readout_done     (readout_done),
        .trig_pop         (trig_pop),
        .acq_pop          (acq_pop),
        .initiate_readout (initiate_readout),
        .readout          (readout),
        .error_trig_num   (error_trig_num),
        .error_trig_type  (error_trig_type)
    );

endmodule

`default_nettype wire

// ==== rtl/ttc_trigger_receiver.sv ====
// TTC trigger receiver
`timescale 1ns/1ps
`default_nettype none

module ttc_trigger_receiver (
    input  wire                                 ttc_clk,               // 40 MHz TTC clock
    input  wire                                 rst,
    input  wire                                 rst_trigger_num,       // TTC channel B
    input  wire                                 rst_trigger_timestamp, // TTC channel B
    input  wire                                 ttc_trigger,
    input  wire [trigger_pkg::TRIG_TYPE_W-1:0]  trig_type,
    input  wire                                 acq_ready,  // controller idle
    input  wire                                 fifo_full,  // trigger FIFO
    output logic                                acq_trigger,
    output trigger_pkg::acq_event_t             acq_event,
    output logic                                fifo_push,
    output trigger_pkg::trig_info_t             fifo_data,
    output logic                                error_trig_rate // sticky
);

    logic [trigger_pkg::TIMESTAMP_W-1:0] ts_cnt;       // free running
    logic [trigger_pkg::TRIG_NUM_W-1:0]  trig_num_cnt; // next number to hand out
    logic                                accept;
    logic                                accept_q;
    trigger_pkg::trig_info_t             trig_rec;     // capture of the accepted trigger

    // busy also while the previous acceptance is still on its way out
    assign accept = ttc_trigger & acq_ready & ~fifo_full & ~accept_q;

    // ----------------------------------------------------------------------
    // counters
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst || rst_trigger_timestamp) begin
            ts_cnt <= '0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (rst || rst_trigger_num) begin
            trig_num_cnt <= trigger_pkg::FIRST_TRIG_NUM;
        end else if (accept) begin
            trig_num_cnt <= trig_num_cnt + 1'b1; // rejected triggers leave no gap
        end
    end

    // ----------------------------------------------------------------------
    // capture and error
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            trig_rec.timestamp <= ts_cnt; // value of the sampling cycle
            trig_rec.trig_num  <= trig_num_cnt;
            trig_rec.trig_type <= trig_type;
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            accept_q        <= 1'b0;
            error_trig_rate <= 1'b0;
        end else begin
            accept_q <= accept;
            if (ttc_trigger && !accept) begin
                error_trig_rate <= 1'b1; // trigger came while busy or FIFO full
            end
        end
    end

    // one pulse drives both the controller and the trigger FIFO
    assign acq_trigger = accept_q;
    assign fifo_push   = accept_q;
    assign fifo_data   = trig_rec;

    assign acq_event.trig_num  = trig_rec.trig_num;
    assign acq_event.trig_type = trig_rec.trig_type;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and grade the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module trigger_top_tb -o trigger_top_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/trigger_top_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

// ==== tb.f ====
rtl/trigger_pkg.sv
rtl/event_fifo.sv
rtl/ttc_trigger_receiver.sv
rtl/channel_acq_controller.sv
rtl/trigger_processor.sv
rtl/trigger_top.sv
test/trigger_top_tb.sv

// ==== test/trigger_top_tb.sv ====
// Trigger manager testbench
`timescale 1ns/1ps
`default_nettype none

module trigger_top_tb;

    localparam int TIMEOUT_CYCLES = 4000; // ~40 triggers, delays up to 12, dones up to 8

    logic                                ttc_clk;
    logic                                rst;
    logic                                rst_trigger_num;
    logic                                rst_trigger_timestamp;
    logic                                ttc_trigger;
    logic [trigger_pkg::TRIG_TYPE_W-1:0] trig_type;
    trigger_pkg::chan_mask_t             chan_en;
    logic [trigger_pkg::DELAY_W-1:0]     trig_delay;
    trigger_pkg::chan_mask_t             chan_dones = '0;
    logic                                readout_done = 1'b0;
    trigger_pkg::chan_mask_t             chan_enable;
    trigger_pkg::chan_mask_t             chan_trig;
    logic                                initiate_readout;
    trigger_pkg::readout_info_t          readout;
    logic                                trig_fifo_full;
    logic                                acq_fifo_full;
    logic                                error_trig_rate;
    logic                                error_trig_num;
    logic                                error_trig_type;

    // reference model state
    int                                  seed = 32'h546472f4;
    int                                  errors = 0;
    int                                  checks = 0;
    int                                  cycles = 0;
    logic                                expect_accept; // stimulus marks triggers it wants taken
    logic [trigger_pkg::TIMESTAMP_W-1:0] ref_ts;
    logic [trigger_pkg::TRIG_NUM_W-1:0]  ref_trig_num;
    logic [trigger_pkg::TRIG_NUM_W-1:0]  ref_event_num;
    trigger_pkg::readout_info_t          exp_q[$];      // readouts still owed
    trigger_pkg::readout_info_t          exp_ro;
    int                                  fire_cnt;      // cycles to channel trigger, -1 idle
    trigger_pkg::chan_mask_t             fire_mask;
    logic                                en_active;     // chan_enable should hold the mask
    trigger_pkg::chan_mask_t             done_seen;
    logic                                rate_exp;
    logic                                prev_init;
    logic                                prev_done;
    trigger_pkg::readout_info_t          prev_readout;
    int                                  done_cnt[trigger_pkg::NUM_CHAN];
    int                                  ack_cnt;
    logic                                ack_armed;

    trigger_top dut (
        .ttc_clk               (ttc_clk),
        .rst                   (rst),
        .rst_trigger_num       (rst_trigger_num),
        .rst_trigger_timestamp (rst_trigger_timestamp),
        .ttc_trigger           (ttc_trigger),
        .trig_type             (trig_type),
        .chan_en               (chan_en),
        .trig_delay            (trig_delay),
        .chan_dones            (chan_dones),
        .chan_enable           (chan_enable),
        .chan_trig             (chan_trig),
        .readout_done          (readout_done),
        .initiate_readout      (initiate_readout),
        .readout               (readout),
        .trig_fifo_full        (trig_fifo_full),
        .acq_fifo_full         (acq_fifo_full),
        .error_trig_rate       (error_trig_rate),
        .error_trig_num        (error_trig_num),
        .error_trig_type       (error_trig_type)
    );

    initial begin
        ttc_clk = 1'b0;
        forever #4 ttc_clk = ~ttc_clk; // 8 ns
    end

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        errors++;
        $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
    endtask

    // ----------------------------------------------------------------------
    // reference model and checks, sampled on the rising edge
    // ----------------------------------------------------------------------
    always @(posedge ttc_clk) begin
        trigger_pkg::chan_mask_t exp_trig;
        if (rst) begin
            ref_event_num = 1;
            fire_cnt      = -1;
            en_active     = 1'b0;
            rate_exp      = 1'b0;
            prev_init     = 1'b0;
            prev_done     = 1'b0;
        end else begin
            checks++;
            // channel trigger and enable window
            if (fire_cnt > 0) fire_cnt--;
            exp_trig = (fire_cnt == 0) ? fire_mask : '0;
            assert (chan_trig == exp_trig)
                else report_mismatch("chan_trig", exp_trig, chan_trig);
            assert (chan_enable == ((en_active || fire_cnt == 0) ? fire_mask : '0))
                else report_mismatch("chan_enable", en_active ? fire_mask : exp_trig, chan_enable);
            if (fire_cnt == 0) begin
                en_active = 1'b1;
                done_seen = '0;
                fire_cnt  = -1;
            end else if (en_active) begin
                done_seen = done_seen | chan_dones;
                if ((done_seen & fire_mask) == fire_mask) en_active = 1'b0; // logged next
            end
            // sticky flags
            assert (error_trig_rate == rate_exp)
                else report_mismatch("error_trig_rate", rate_exp, error_trig_rate);
            assert (!error_trig_num) else report_mismatch("error_trig_num", 0, error_trig_num);
            assert (!error_trig_type) else report_mismatch("error_trig_type", 0, error_trig_type);
            // each FIFO holds at most the readouts still owed
            if (exp_q.size() < trigger_pkg::FIFO_DEPTH) begin
                assert (!trig_fifo_full)
                    else report_mismatch("trig_fifo_full", 0, trig_fifo_full);
                assert (!acq_fifo_full)
                    else report_mismatch("acq_fifo_full", 0, acq_fifo_full);
            end
            // four-phase readout
            if (prev_init && !prev_done) begin
                assert (initiate_readout) else report_mismatch("req_held", 1, initiate_readout);
                assert (readout == prev_readout)
                    else report_mismatch("readout_stable", prev_readout, readout);
            end
            if (prev_init && prev_done) begin
                assert (!initiate_readout) else report_mismatch("req_drop", 0, initiate_readout);
            end
            if (initiate_readout && !prev_init) begin
                assert (!prev_done) else report_mismatch("req_rise_ack_low", 0, prev_done);
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("readout requested with no accepted trigger outstanding");
                end else begin
                    exp_ro = exp_q.pop_front();
                    assert (readout.event_num == exp_ro.event_num)
                        else report_mismatch("event_num", exp_ro.event_num, readout.event_num);
                    assert (readout.trig_num == exp_ro.trig_num)
                        else report_mismatch("trig_num", exp_ro.trig_num, readout.trig_num);
                    assert (readout.trig_type == exp_ro.trig_type)
                        else report_mismatch("trig_type", exp_ro.trig_type, readout.trig_type);
                    assert (readout.timestamp == exp_ro.timestamp)
                        else report_mismatch("timestamp", exp_ro.timestamp, readout.timestamp);
                end
            end
            // trigger sampled this cycle
            if (ttc_trigger && expect_accept) begin
                exp_ro.event_num = ref_event_num;
                exp_ro.trig_num  = ref_trig_num;
                exp_ro.trig_type = trig_type;
                exp_ro.timestamp = ref_ts;
                exp_q.push_back(exp_ro);
                ref_event_num++;
                ref_trig_num++; // rejected ones leave no gap
                fire_cnt  = int'(trig_delay) + 2;
                fire_mask = chan_en;
            end
            if (ttc_trigger && !expect_accept) rate_exp = 1'b1;
            prev_init    = initiate_readout;
            prev_done    = readout_done;
            prev_readout = readout;
        end
        // channel B resets win over the increment
        if (rst || rst_trigger_num) ref_trig_num = 1;
        if (rst || rst_trigger_timestamp) ref_ts = '0;
        else ref_ts = ref_ts + 1'b1;
    end

    // ----------------------------------------------------------------------
    // channel and command manager models, driven on the falling edge
    // ----------------------------------------------------------------------
    always @(negedge ttc_clk) begin
        if (rst) begin
            chan_dones   <= '0;
            readout_done <= 1'b0;
            ack_cnt   = 0;
            ack_armed = 1'b0;
            for (int i = 0; i < trigger_pkg::NUM_CHAN; i++) done_cnt[i] = 0;
        end else begin
            for (int i = 0; i < trigger_pkg::NUM_CHAN; i++) begin
                if (chan_trig[i]) begin
                    done_cnt[i] = 1 + ($unsigned($random(seed)) % 8); // 1..8 cycles
                end else if (done_cnt[i] > 0) begin
                    done_cnt[i]--;
                    if (done_cnt[i] == 0) chan_dones[i] <= 1'b1;
                end
            end
            if (chan_enable == '0 && chan_trig == '0) chan_dones <= '0;
            // ack after a random wait, release right after req drops
            if (ack_cnt > 0) begin
                ack_cnt--;
            end else if (initiate_readout && !readout_done) begin
                if (ack_armed) begin
                    readout_done <= 1'b1;
                    ack_armed = 1'b0;
                end else begin
                    ack_cnt   = $unsigned($random(seed)) % 6;
                    ack_armed = 1'b1;
                end
            end else if (!initiate_readout && readout_done) begin
                readout_done <= 1'b0;
            end
        end
    end

    always @(posedge ttc_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks %0d, errors %0d", checks, errors);
            $display("sim failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic fire_trigger(input logic accepted);
        @(negedge ttc_clk);
        ttc_trigger   = 1'b1;
        expect_accept = accepted;
        trig_type     = $random(seed);
        @(negedge ttc_clk);
        ttc_trigger   = 1'b0;
        expect_accept = 1'b0;
    endtask

    // controller idle again once the event is logged
    task automatic wait_acq_done;
        while (chan_trig == '0) @(posedge ttc_clk);
        @(posedge ttc_clk);
        while (chan_enable != '0) @(posedge ttc_clk);
        @(negedge ttc_clk); // back on the drive edge
    endtask

    task automatic run_triggers(input int count);
        for (int n = 0; n < count; n++) begin
            chan_en = trigger_pkg::chan_mask_t'($random(seed));
            if (chan_en == '0) chan_en = 5'b00001; // at least one channel
            trig_delay = $unsigned($random(seed)) % 13;
            fire_trigger(1'b1);
            wait_acq_done();
            repeat ($unsigned($random(seed)) % 4) @(negedge ttc_clk);
        end
    endtask

    task automatic pulse_channel_b(input logic num_reset, input logic ts_reset);
        @(negedge ttc_clk);
        rst_trigger_num       = num_reset;
        rst_trigger_timestamp = ts_reset;
        @(negedge ttc_clk);
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
    endtask

    initial begin
        rst                   = 1'b1;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        ttc_trigger           = 1'b0;
        expect_accept         = 1'b0;
        trig_type             = '0;
        chan_en               = '1;
        trig_delay            = 8'd3;
        repeat (2) @(posedge ttc_clk);
        @(negedge ttc_clk);
        rst = 1'b0;
        repeat (3) @(negedge ttc_clk);

        run_triggers(14);
        pulse_channel_b(1'b1, 1'b0); // numbering back to 1
        run_triggers(6);
        pulse_channel_b(1'b0, 1'b1); // timestamp back to 0
        run_triggers(6);

        // second trigger lands in the delay window of the first
        chan_en    = 5'b10101;
        trig_delay = 8'd10;
        fire_trigger(1'b1);
        repeat (3) @(negedge ttc_clk);
        fire_trigger(1'b0);
        wait_acq_done();
        run_triggers(10);

        while (exp_q.size() != 0 || initiate_readout || readout_done) @(posedge ttc_clk);
        @(negedge ttc_clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
